//--- source/psum_buf_cfg.svh
// psum buffer configuration
// bus, burst and FIFO sizing for the partial-sum buffering path
`ifndef PSUM_BUF_CFG_SVH
`define PSUM_BUF_CFG_SVH

// AXI data bus and partial sum width
`define PSUM_DATA_W 32

// one read burst and the bursts per buffering request
`define PSUM_BURST_LEN 16
`define PSUM_BURSTS 3
`define PSUM_BYTES_PER_WORD 4

// psum FIFO depth in words, a power of two
`define PSUM_FIFO_DEPTH 64

// read address shown while no burst is pending
`define PSUM_AXI_BASE_DEFAULT 32'h4000_0000

`endif

//--- source/psum_buf_pkg.sv
// psum buffer types
// word type, acc_params register layout and FSM state encodings
`include "psum_buf_cfg.svh"

package psum_buf_pkg;

  typedef logic [`PSUM_DATA_W-1:0] psum_word_t;

  // acc_params register, msb first
  typedef struct packed {
    logic        rsvd_31;
    logic        start;
    logic        soft_reset;
    logic [12:0] rsvd_28_16;
    logic [3:0]  tile_size;
    logic [7:0]  rsvd_11_4;
    logic [3:0]  filter_r;
  } acc_params_t;

  typedef enum logic [1:0] {
    IDLE_BUFFER,
    ISSUE_RD,
    WAIT_RD,
    BUFFER_DONE
  } rd_state_e;

  typedef enum logic [0:0] {
    FEED_IDLE,
    FEEDING
  } feed_state_e;

endpackage

//--- source/psum_fill_if.sv
// psum fill link
// write strobe, write data and clear from the burst reader into the psum FIFO
`timescale 1ns/1ns

interface psum_fill_if
  import psum_buf_pkg::*;
();

  logic       wr_en;
  psum_word_t wr_data;
  // one-cycle pulse, beats a write in the same cycle
  logic       clear;
  logic       full;

  modport writer (
    output wr_en,
    output wr_data,
    output clear,
    input  full
  );

  modport store (
    input  wr_en,
    input  wr_data,
    input  clear,
    output full
  );

endinterface

//--- source/burst_reader.sv
// psum burst reader
// issues the read bursts of one psum buffering request and streams
// the returned words into the psum FIFO
`timescale 1ns/1ns
`include "psum_buf_cfg.svh"

module burst_reader
  import psum_buf_pkg::*;
(
  input  logic        CLK,
  input  logic        rst_n,
  input  logic        buffer_req,
  input  logic        clear_req,
  input  psum_word_t  base_addr,
  input  psum_word_t  m_axi_rdata,
  input  logic        m_axi_rvalid_rready,
  input  logic        txn_done,
  input  logic        axi_error,
  output psum_word_t  m_ar_addr,
  output logic        init_axi_rd_txn,
  output logic        psums_buffered,
  output logic        buffer_error,
  psum_fill_if.writer fill
);

  // byte step between consecutive bursts
  localparam int BURST_STEP = `PSUM_BURST_LEN * `PSUM_BYTES_PER_WORD;
  localparam int CNT_W = $clog2(`PSUM_BURSTS + 1);
  localparam logic [CNT_W-1:0] LAST_CNT = `PSUM_BURSTS;

  rd_state_e        state;
  rd_state_e        state_next;
  logic             buffer_req_q;
  logic             clear_req_q;
  logic             buffer_pulse;
  logic [CNT_W-1:0] burst_cnt;
  logic             last_burst;
  psum_word_t       addr_offset;

  // rising edges of the mem_ctrl level bits
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      buffer_req_q <= 1'b0;
      clear_req_q  <= 1'b0;
    end else begin
      buffer_req_q <= buffer_req;
      clear_req_q  <= clear_req;
    end
  end

  assign buffer_pulse = buffer_req & ~buffer_req_q;
  assign fill.clear   = clear_req & ~clear_req_q;

  // read data goes straight to the FIFO, aligned with the strobe
  assign fill.wr_en   = (state == WAIT_RD) & m_axi_rvalid_rready;
  assign fill.wr_data = m_axi_rdata;

  // burst_cnt counts bursts already issued
  assign last_burst = (burst_cnt == LAST_CNT);

  always_comb begin
    state_next = state;
    case (state)
      IDLE_BUFFER: begin
        if (buffer_pulse) begin
          state_next = ISSUE_RD;
        end
      end
      ISSUE_RD: state_next = WAIT_RD;
      WAIT_RD: begin
        if (txn_done) begin
          state_next = last_burst ? BUFFER_DONE : ISSUE_RD;
        end
      end
      BUFFER_DONE: state_next = IDLE_BUFFER;
      default: state_next = IDLE_BUFFER;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      state           <= IDLE_BUFFER;
      burst_cnt       <= '0;
      addr_offset     <= '0;
      init_axi_rd_txn <= 1'b0;
      m_ar_addr       <= `PSUM_AXI_BASE_DEFAULT;
      psums_buffered  <= 1'b0;
      buffer_error    <= 1'b0;
    end else begin
      state           <= state_next;
      init_axi_rd_txn <= 1'b0;
      case (state)
        IDLE_BUFFER: begin
          if (buffer_pulse) begin
            burst_cnt      <= '0;
            addr_offset    <= '0;
            psums_buffered <= 1'b0;
            buffer_error   <= 1'b0;
          end
        end
        ISSUE_RD: begin
          init_axi_rd_txn <= 1'b1;
          m_ar_addr       <= base_addr + addr_offset;
          addr_offset     <= addr_offset + psum_word_t'(BURST_STEP);
          burst_cnt       <= burst_cnt + 1'b1;
        end
        WAIT_RD: begin
          // word lost on a full FIFO
          if (fill.wr_en && fill.full) begin
            buffer_error <= 1'b1;
          end
          if (txn_done) begin
            if (axi_error) begin
              buffer_error <= 1'b1;
            end
            if (last_burst) begin
              psums_buffered <= 1'b1;
            end
          end
        end
        BUFFER_DONE: m_ar_addr <= `PSUM_AXI_BASE_DEFAULT;
        default: ;
      endcase
    end
  end

endmodule

//--- source/psum_fifo.sv
// psum FIFO
// circular buffer of partial sums between the burst reader and the feeder
`timescale 1ns/1ns
`include "psum_buf_cfg.svh"

module psum_fifo
  import psum_buf_pkg::*;
(
  input  logic       CLK,
  input  logic       rst_n,
  input  logic       pop,
  output psum_word_t pop_data,
  output logic       empty,
  psum_fill_if.store fill
);

  localparam int AW = $clog2(`PSUM_FIFO_DEPTH);
  localparam logic [AW:0] DEPTH_CNT = `PSUM_FIFO_DEPTH;

  psum_word_t    mem [`PSUM_FIFO_DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;
  logic          do_wr;
  logic          do_rd;

  assign fill.full = (count == DEPTH_CNT);
  assign empty     = (count == '0);
  assign do_wr     = fill.wr_en & ~fill.full;
  assign do_rd     = pop & ~empty;

  // head word, no read latency
  assign pop_data = mem[rd_ptr];

  always_ff @(posedge CLK) begin
    if (do_wr) begin
      mem[wr_ptr] <= fill.wr_data;
    end
  end

  // pointers wrap naturally
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (fill.clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: ;
      endcase
    end
  end

endmodule

//--- source/psum_feeder.sv
// psum feeder
// drains tile_size x R partial sums from the FIFO toward the PE array
`timescale 1ns/1ns

module psum_feeder
  import psum_buf_pkg::*;
(
  input  logic       CLK,
  input  logic       rst_n,
  input  logic       start,
  input  logic [3:0] tile_size,
  input  logic [3:0] param_r,
  input  logic       act_valid,
  input  psum_word_t pop_data,
  input  logic       empty,
  output logic       pop,
  output psum_word_t in_psum_out,
  output logic       in_psum_valid,
  output logic       feed_done
);

  feed_state_e state;
  logic        start_q;
  logic        start_pulse;
  logic [7:0]  word_limit;
  logic [7:0]  limit;
  logic [7:0]  feed_cnt;
  logic        last_word;

  assign start_pulse = start & ~start_q;
  assign word_limit  = tile_size * param_r;
  assign last_word   = (feed_cnt == limit - 8'd1);

  // one word per valid activation, stall on an empty FIFO
  assign pop = (state == FEEDING) & act_valid & ~empty;

  always_ff @(posedge CLK) begin
    if (pop) begin
      in_psum_out <= pop_data;
    end
  end

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      state         <= FEED_IDLE;
      start_q       <= 1'b0;
      in_psum_valid <= 1'b0;
      feed_done     <= 1'b0;
      feed_cnt      <= '0;
      limit         <= '0;
    end else begin
      start_q       <= start;
      in_psum_valid <= pop;
      case (state)
        FEED_IDLE: begin
          if (start_pulse) begin
            feed_cnt <= '0;
            limit    <= word_limit;
            // nothing to feed for a zero-sized tile
            if (word_limit == '0) begin
              feed_done <= 1'b1;
            end else begin
              feed_done <= 1'b0;
              state     <= FEEDING;
            end
          end
        end
        FEEDING: begin
          if (pop) begin
            feed_cnt <= feed_cnt + 8'd1;
            if (last_word) begin
              feed_done <= 1'b1;
              state     <= FEED_IDLE;
            end
          end
        end
        default: state <= FEED_IDLE;
      endcase
    end
  end

endmodule

//--- source/psum_buffer_top.sv
// psum buffering top
// decodes the control registers and ties the burst reader, psum FIFO
// and feeder together
`timescale 1ns/1ns

module psum_buffer_top
  import psum_buf_pkg::*;
(
  input  logic        CLK,
  input  logic        RESETN,
  input  acc_params_t acc_params,
  input  psum_word_t  output_base_addr,
  input  psum_word_t  mem_ctrl,
  input  logic        act_valid,
  input  psum_word_t  m_axi_rdata,
  input  logic        m_axi_rvalid_rready,
  input  logic        txn_done,
  input  logic        axi_error,
  output psum_word_t  pe_status,
  output psum_word_t  in_psum_out,
  output logic        in_psum_valid,
  output psum_word_t  m_ar_addr,
  output logic        init_axi_rd_txn
);

  // mem_ctrl bits
  localparam int MEM_BUFFER_PSUMS = 6;
  localparam int MEM_CLEAR_PSUMS  = 7;

  // pe_status bits
  localparam int ST_PSUMS_BUFFERED = 0;
  localparam int ST_FEED_DONE      = 1;
  localparam int ST_PSUM_ERROR     = 16;

  logic       rst_n;
  logic       buffer_req;
  logic       clear_req;
  logic       psums_buffered;
  logic       buffer_error;
  logic       feed_done;
  logic       fifo_pop;
  logic       fifo_empty;
  psum_word_t fifo_pop_data;

  psum_fill_if u_fill ();

  // soft reset acts like the external reset
  assign rst_n      = RESETN & ~acc_params.soft_reset;
  assign buffer_req = mem_ctrl[MEM_BUFFER_PSUMS];
  assign clear_req  = mem_ctrl[MEM_CLEAR_PSUMS];

  // every status bit is a flag register in the reader or feeder
  always_comb begin
    pe_status                    = '0;
    pe_status[ST_PSUMS_BUFFERED] = psums_buffered;
    pe_status[ST_FEED_DONE]      = feed_done;
    pe_status[ST_PSUM_ERROR]     = buffer_error;
  end

  burst_reader u_burst_reader (
    .CLK                 (CLK),
    .rst_n               (rst_n),
    .buffer_req          (buffer_req),
    .clear_req           (clear_req),
    .base_addr           (output_base_addr),
    .m_axi_rdata         (m_axi_rdata),
    .m_axi_rvalid_rready (m_axi_rvalid_rready),
    .txn_done            (txn_done),
    .axi_error           (axi_error),
    .m_ar_addr           (m_ar_addr),
    .init_axi_rd_txn     (init_axi_rd_txn),
    .psums_buffered      (psums_buffered),
    .buffer_error        (buffer_error),
    .fill                (u_fill.writer)
  );

  psum_fifo u_psum_fifo (
    .CLK      (CLK),
    .rst_n    (rst_n),
    .pop      (fifo_pop),
    .pop_data (fifo_pop_data),
    .empty    (fifo_empty),
    .fill     (u_fill.store)
  );

  psum_feeder u_psum_feeder (
    .CLK           (CLK),
    .rst_n         (rst_n),
    .start         (acc_params.start),
    .tile_size     (acc_params.tile_size),
    .param_r       (acc_params.filter_r),
    .act_valid     (act_valid),
    .pop_data      (fifo_pop_data),
    .empty         (fifo_empty),
    .pop           (fifo_pop),
    .in_psum_out   (in_psum_out),
    .in_psum_valid (in_psum_valid),
    .feed_done     (feed_done)
  );

endmodule

//--- tb/psum_buffer_chk.sv
// psum buffer checker
// reset and read request assertions on the psum buffering top
`timescale 1ns/1ns

module psum_buffer_chk
  import psum_buf_pkg::*;
(
  input logic       CLK,
  input logic       RESETN,
  input logic       rst_n,
  input logic       init_axi_rd_txn,
  input logic       in_psum_valid,
  input psum_word_t pe_status
);

  int fail_count = 0;

  // read request is a single-cycle pulse
  a_rd_pulse: assert property (@(posedge CLK) disable iff (!rst_n)
    init_axi_rd_txn |=> !init_axi_rd_txn)
  else begin
    fail_count++;
    $error("init_axi_rd_txn stayed high for two cycles");
  end

  a_valid_reset: assert property (@(posedge CLK) !rst_n |=> !in_psum_valid)
  else begin
    fail_count++;
    $error("in_psum_valid high right after a reset cycle");
  end

  // flags clear on the edge that samples RESETN low
  a_status_reset: assert property (@(posedge CLK) !RESETN |=> pe_status == '0)
  else begin
    fail_count++;
    $error("pe_status not cleared by RESETN");
  end

endmodule

bind psum_buffer_top psum_buffer_chk u_psum_buffer_chk (
  .CLK             (CLK),
  .RESETN          (RESETN),
  .rst_n           (rst_n),
  .init_axi_rd_txn (init_axi_rd_txn),
  .in_psum_valid   (in_psum_valid),
  .pe_status       (pe_status)
);

//--- tb/psum_buffer_tb.sv
// psum buffer testbench
// AXI read responder, PE-side stimulus and checks for psum_buffer_top
`timescale 1ns/1ns
`include "psum_buf_cfg.svh"

module psum_buffer_tb
  import psum_buf_pkg::*;
();

  localparam int WORDS = `PSUM_BURST_LEN * `PSUM_BURSTS;
  localparam int STEP = `PSUM_BURST_LEN * `PSUM_BYTES_PER_WORD;
  // at most 3 idle cycles before each returned word
  localparam int GAP_BOUND = WORDS * 3;
  localparam int TIMEOUT_CYCLES = 4 * (WORDS + WORDS + GAP_BOUND) + 200;
  localparam int BUFFER_BIT = 6;
  localparam int CLEAR_BIT = 7;

  logic        CLK;
  logic        RESETN;
  acc_params_t acc_params;
  psum_word_t  output_base_addr;
  psum_word_t  mem_ctrl;
  logic        act_valid;
  psum_word_t  m_axi_rdata;
  logic        m_axi_rvalid_rready;
  logic        txn_done;
  logic        axi_error;
  psum_word_t  pe_status;
  psum_word_t  in_psum_out;
  logic        in_psum_valid;
  psum_word_t  m_ar_addr;
  logic        init_axi_rd_txn;

  // tile, R, base, error burst, then the memory image
  psum_word_t  vectors [0:WORDS+3];
  logic [15:0] lfsr = 16'd51;
  int          cycles = 0;
  int          rd_pulses = 0;

  psum_buffer_top u_psum_buffer_top (.*);

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: test did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("*** FAILED ***");
      $fatal(1, "simulation timed out");
    end
  end

  always @(negedge CLK) begin
    if (init_axi_rd_txn === 1'b1) begin
      rd_pulses <= rd_pulses + 1;
    end
  end

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic rand_bits(input int n, output int val);
    val = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      val = (val << 1) | int'(lfsr[0]);
    end
  endtask

  task automatic check_word(input string name, input psum_word_t exp, input psum_word_t act);
    if (act !== exp) begin
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
      $display("*** FAILED ***");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
      $display("*** FAILED ***");
      $fatal(1, "value mismatch");
    end
  endtask

  // one buffering request answered burst by burst from the memory image
  task automatic run_buffering(input int err_burst);
    int gap;
    int pulses_before;
    pulses_before = rd_pulses;
    mem_ctrl[BUFFER_BIT] = 1'b1;
    for (int b = 0; b < `PSUM_BURSTS; b++) begin
      @(negedge CLK);
      while (init_axi_rd_txn !== 1'b1) begin
        @(negedge CLK);
      end
      check_word("burst address", vectors[2] + psum_word_t'(b * STEP), m_ar_addr);
      for (int w = 0; w < `PSUM_BURST_LEN; w++) begin
        rand_bits(2, gap);
        m_axi_rvalid_rready = 1'b0;
        repeat (gap) @(negedge CLK);
        m_axi_rvalid_rready = 1'b1;
        m_axi_rdata = vectors[4 + b * `PSUM_BURST_LEN + w];
        @(negedge CLK);
      end
      m_axi_rvalid_rready = 1'b0;
      txn_done = 1'b1;
      axi_error = (b == err_burst);
      @(negedge CLK);
      txn_done = 1'b0;
      axi_error = 1'b0;
    end
    check_bit("psums buffered", 1'b1, pe_status[0]);
    check_bit("buffer error", err_burst >= 0, pe_status[16]);
    mem_ctrl[BUFFER_BIT] = 1'b0;
    repeat (10) @(negedge CLK);
    check_word("read pulse count", psum_word_t'(`PSUM_BURSTS),
               psum_word_t'(rd_pulses - pulses_before));
  endtask

  initial begin
    int total;
    int got;
    int bitv;
    $readmemh("tb/psum_buffer_vectors.mem", vectors);
    RESETN = 1'b0;
    acc_params = '0;
    acc_params.tile_size = vectors[0][3:0];
    acc_params.filter_r = vectors[1][3:0];
    output_base_addr = vectors[2];
    mem_ctrl = '0;
    act_valid = 1'b0;
    m_axi_rdata = '0;
    m_axi_rvalid_rready = 1'b0;
    txn_done = 1'b0;
    axi_error = 1'b0;
    total = int'(vectors[0][3:0]) * int'(vectors[1][3:0]);
    repeat (2) @(negedge CLK);
    RESETN = 1'b1;

    check_word("reset status", '0, pe_status);
    check_bit("reset psum valid", 1'b0, in_psum_valid);
    check_bit("reset read pulse", 1'b0, init_axi_rd_txn);
    check_word("reset read address", `PSUM_AXI_BASE_DEFAULT, m_ar_addr);

    run_buffering(-1);

    // feed under random activations
    acc_params.start = 1'b1;
    got = 0;
    while (got < total) begin
      rand_bits(1, bitv);
      act_valid = bitv[0];
      @(negedge CLK);
      if (in_psum_valid === 1'b1) begin
        check_word("fed psum", vectors[4 + got], in_psum_out);
        check_bit("feed done", got == total - 1, pe_status[1]);
        got++;
      end
    end
    repeat (20) begin
      rand_bits(1, bitv);
      act_valid = bitv[0];
      @(negedge CLK);
      check_bit("no word after feed", 1'b0, in_psum_valid);
    end
    check_bit("feed done held", 1'b1, pe_status[1]);

    // clear the FIFO and start again
    acc_params.start = 1'b0;
    act_valid = 1'b0;
    mem_ctrl[CLEAR_BIT] = 1'b1;
    @(negedge CLK);
    mem_ctrl[CLEAR_BIT] = 1'b0;
    @(negedge CLK);
    acc_params.start = 1'b1;
    act_valid = 1'b1;
    repeat (50) begin
      @(negedge CLK);
      check_bit("no word after clear", 1'b0, in_psum_valid);
    end
    check_bit("feed done after restart", 1'b0, pe_status[1]);

    act_valid = 1'b0;
    run_buffering(int'(vectors[3]));

    // soft reset while the feeder is busy
    act_valid = 1'b1;
    @(negedge CLK);
    while (in_psum_valid !== 1'b1) begin
      @(negedge CLK);
    end
    acc_params.soft_reset = 1'b1;
    acc_params.start = 1'b0;
    @(negedge CLK);
    check_word("soft reset status", '0, pe_status);
    check_bit("soft reset psum valid", 1'b0, in_psum_valid);
    @(negedge CLK);
    acc_params.soft_reset = 1'b0;
    repeat (20) begin
      @(negedge CLK);
      check_bit("no feed after soft reset", 1'b0, in_psum_valid);
    end
    check_word("status after soft reset", '0, pe_status);

    if (u_psum_buffer_top.u_psum_buffer_chk.fail_count != 0) begin
      $display("assertion failures: %0d", u_psum_buffer_top.u_psum_buffer_chk.fail_count);
      $display("*** FAILED ***");
      $fatal(1, "assertions failed");
    end else begin
      $display("*** PASSED ***");
      $finish;
    end
  end

endmodule

//--- psum_buffer_top.f
+incdir+source
source/psum_buf_pkg.sv
source/psum_fill_if.sv
source/burst_reader.sv
source/psum_fifo.sv
source/psum_feeder.sv
source/psum_buffer_top.sv
tb/psum_buffer_chk.sv
tb/psum_buffer_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the psum buffer testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module psum_buffer_tb -f psum_buffer_top.f --Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vpsum_buffer_tb +verilator+error+limit+100 > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -qF '*** PASSED ***' sim.log; then
  exit 0
fi
exit 1

//--- tb/psum_buffer_vectors.mem
// word 0 tile size, word 1 filter R, word 2 base address, word 3 burst with axi_error
// then 48 memory words, 8 per line, in burst order
00000004
00000003
20001000
00000001
0000a101 0000b202 7fff0003 80000004 12345678 0badf00d 00000000 ffffffff
13572468 24681357 00c0ffee 5a5a5a5a a5a5a5a5 00010001 fffe0002 33334444
00000111 00000222 00000333 00000444 00000555 00000666 00000777 00000888
10203040 50607080 90a0b0c0 d0e0f000 01020304 05060708 090a0b0c 0d0e0f10
deadbeef cafebabe 11112222 55556666 77778888 9999aaaa bbbbcccc ddddeeee
0f0f0f0f f0f0f0f0 00ff00ff ff00ff00 3c3c3c3c c3c3c3c3 6e6e6e6e 00000042
